// ==== src/cache_subsys_settings.svh ====
`ifndef CACHE_SUBSYS_SETTINGS_SVH
`define CACHE_SUBSYS_SETTINGS_SVH

// byte address width of core and memory side
`define CS_ADDR_WIDTH 32

// one word per cache line
`define CS_DATA_WIDTH 32

// direct-mapped line counts, powers of two
`define CS_ICACHE_LINES 16
`define CS_DCACHE_LINES 16

// lines are word sized, so two offset bits below the index
`define CS_OFFSET_BITS 2

`endif

// ==== src/cache_subsys_pkg.sv ====
`default_nettype none

`include "cache_subsys_settings.svh"

package cache_subsys_pkg;

  // memory bus opcode
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // controller states shared by both caches
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_LOOKUP = 3'd1,
    ST_REFILL = 3'd2,
    ST_WRITE  = 3'd3,
    ST_FLUSH  = 3'd4
  } cache_state_e;

  // request from a core to one cache
  typedef struct packed {
    mem_op_e                   op;
    logic [`CS_ADDR_WIDTH-1:0] addr;
    logic [`CS_DATA_WIDTH-1:0] wdata;
  } core_req_t;

  // request on the shared memory bus
  typedef struct packed {
    mem_op_e                   op;
    logic [`CS_ADDR_WIDTH-1:0] addr;
    logic [`CS_DATA_WIDTH-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_subsys_settings.svh"

module icache_ctrl import cache_subsys_pkg::*; #(
  parameter int unsigned NUM_LINES = `CS_ICACHE_LINES
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      enable_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o,
  output logic                      miss_o,
  input  logic                      req_valid_i,
  input  core_req_t                 req_i,
  output logic                      rsp_valid_o,
  output logic [`CS_DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                      mem_req_valid_o,
  output mem_req_t                  mem_req_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  logic [`CS_DATA_WIDTH-1:0] mem_rdata_i
);

  localparam int unsigned IDX_W = $clog2(NUM_LINES);
  localparam int unsigned LSB   = `CS_OFFSET_BITS;
  localparam int unsigned TAG_W = `CS_ADDR_WIDTH - IDX_W - LSB;

  cache_state_e              state_q;
  logic [NUM_LINES-1:0]      valid_q;
  logic [TAG_W-1:0]          tag_q  [NUM_LINES];
  logic [`CS_DATA_WIDTH-1:0] data_q [NUM_LINES];
  logic                      gnt_q;
  logic [IDX_W-1:0]          idx;
  logic [TAG_W-1:0]          tag;
  logic                      hit;
  logic                      req_pending;
  logic                      fill;

  assign idx = req_i.addr[IDX_W+LSB-1:LSB];
  assign tag = req_i.addr[`CS_ADDR_WIDTH-1:IDX_W+LSB];
  assign hit = enable_i && valid_q[idx] && (tag_q[idx] == tag);

  // core keeps req high through the response cycle
  assign req_pending = req_valid_i && !rsp_valid_o;
  assign fill        = (state_q == ST_REFILL) && mem_rvalid_i && enable_i;

  assign miss_o          = (state_q == ST_LOOKUP) && enable_i && !hit;
  assign mem_req_valid_o = (state_q == ST_REFILL) && !gnt_q;
  assign mem_req_o       = '{op: MEM_READ, addr: req_i.addr, wdata: '0};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      valid_q     <= '0;
      gnt_q       <= 1'b0;
      rsp_valid_o <= 1'b0;
      flush_ack_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      flush_ack_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_pending) begin
            state_q <= ST_LOOKUP;
          end else if (flush_i && !flush_ack_o) begin
            state_q <= ST_FLUSH;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            rsp_valid_o <= 1'b1;
            state_q     <= ST_IDLE;
          end else begin
            state_q <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (mem_req_valid_o && mem_gnt_i) begin
            gnt_q <= 1'b1;
          end
          if (mem_rvalid_i) begin
            gnt_q       <= 1'b0;
            rsp_valid_o <= 1'b1;
            state_q     <= ST_IDLE;
          end
          if (fill) begin
            valid_q[idx] <= 1'b1;
          end
        end
        ST_FLUSH: begin
          valid_q     <= '0;
          flush_ack_o <= 1'b1;
          state_q     <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // tag and data arrays, plus the read data register
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_LOOKUP) && hit) begin
      rsp_rdata_o <= data_q[idx];
    end
    if ((state_q == ST_REFILL) && mem_rvalid_i) begin
      rsp_rdata_o <= mem_rdata_i;
    end
    if (fill) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_subsys_settings.svh"

module dcache_ctrl import cache_subsys_pkg::*; #(
  parameter int unsigned NUM_LINES = `CS_DCACHE_LINES
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      enable_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o,
  output logic                      miss_o,
  input  logic                      req_valid_i,
  input  core_req_t                 req_i,
  output logic                      rsp_valid_o,
  output logic [`CS_DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                      mem_req_valid_o,
  output mem_req_t                  mem_req_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  logic [`CS_DATA_WIDTH-1:0] mem_rdata_i
);

  localparam int unsigned IDX_W = $clog2(NUM_LINES);
  localparam int unsigned LSB   = `CS_OFFSET_BITS;
  localparam int unsigned TAG_W = `CS_ADDR_WIDTH - IDX_W - LSB;

  cache_state_e              state_q;
  logic [NUM_LINES-1:0]      valid_q;
  logic [TAG_W-1:0]          tag_q  [NUM_LINES];
  logic [`CS_DATA_WIDTH-1:0] data_q [NUM_LINES];
  logic                      gnt_q;
  logic [IDX_W-1:0]          idx;
  logic [TAG_W-1:0]          tag;
  logic                      line_hit;
  logic                      hit;
  logic                      req_pending;
  logic                      mem_phase;
  logic                      granted;
  logic                      fill;

  assign idx      = req_i.addr[IDX_W+LSB-1:LSB];
  assign tag      = req_i.addr[`CS_ADDR_WIDTH-1:IDX_W+LSB];
  assign line_hit = valid_q[idx] && (tag_q[idx] == tag);

  // a disabled cache never serves a read from its arrays
  assign hit = enable_i && line_hit;

  assign req_pending = req_valid_i && !rsp_valid_o;
  assign mem_phase   = (state_q == ST_REFILL) || (state_q == ST_WRITE);
  assign granted     = mem_req_valid_o && mem_gnt_i;
  assign fill        = (state_q == ST_REFILL) && mem_rvalid_i && enable_i;

  // only reads pass through lookup, so writes never count as misses
  assign miss_o          = (state_q == ST_LOOKUP) && enable_i && !hit;
  assign mem_req_valid_o = mem_phase && !gnt_q;
  assign mem_req_o       = '{op: req_i.op, addr: req_i.addr, wdata: req_i.wdata};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      valid_q     <= '0;
      gnt_q       <= 1'b0;
      rsp_valid_o <= 1'b0;
      flush_ack_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      flush_ack_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_pending) begin
            state_q <= (req_i.op == MEM_WRITE) ? ST_WRITE : ST_LOOKUP;
          end else if (flush_i && !flush_ack_o) begin
            state_q <= ST_FLUSH;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            rsp_valid_o <= 1'b1;
            state_q     <= ST_IDLE;
          end else begin
            state_q <= ST_REFILL;
          end
        end
        ST_REFILL, ST_WRITE: begin
          if (granted) begin
            gnt_q <= 1'b1;
          end
          if (mem_rvalid_i) begin
            gnt_q       <= 1'b0;
            rsp_valid_o <= 1'b1;
            state_q     <= ST_IDLE;
          end
          if (fill) begin
            valid_q[idx] <= 1'b1;
          end
        end
        ST_FLUSH: begin
          valid_q     <= '0;
          flush_ack_o <= 1'b1;
          state_q     <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ST_LOOKUP) && hit) begin
      rsp_rdata_o <= data_q[idx];
    end
    if (mem_phase && mem_rvalid_i) begin
      // writes answer with zero data
      rsp_rdata_o <= (state_q == ST_WRITE) ? '0 : mem_rdata_i;
    end
    if (fill) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= mem_rdata_i;
    end
    // write hit keeps the line coherent, even while disabled
    if ((state_q == ST_WRITE) && granted && line_hit) begin
      data_q[idx] <= req_i.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_subsys_settings.svh"

module mem_arbiter import cache_subsys_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ic_req_valid_i,
  input  mem_req_t                  ic_req_i,
  output logic                      ic_gnt_o,
  output logic                      ic_rvalid_o,
  input  logic                      dc_req_valid_i,
  input  mem_req_t                  dc_req_i,
  output logic                      dc_gnt_o,
  output logic                      dc_rvalid_o,
  output logic [`CS_DATA_WIDTH-1:0] rdata_o,
  output logic                      mem_req_valid_o,
  output mem_req_t                  mem_req_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  logic [`CS_DATA_WIDTH-1:0] mem_rdata_i
);

  logic busy_q;
  logic owner_dc_q;
  logic pick_dc;
  logic granted;

  // fixed priority, data cache first
  assign pick_dc = dc_req_valid_i;

  // bus locked from grant until the response strobe
  assign mem_req_valid_o = !busy_q && (dc_req_valid_i || ic_req_valid_i);
  assign mem_req_o       = pick_dc ? dc_req_i : ic_req_i;
  assign granted         = mem_req_valid_o && mem_gnt_i;

  assign dc_gnt_o = granted && pick_dc;
  assign ic_gnt_o = granted && !pick_dc;

  // response strobe only reaches the owner
  assign dc_rvalid_o = mem_rvalid_i && busy_q && owner_dc_q;
  assign ic_rvalid_o = mem_rvalid_i && busy_q && !owner_dc_q;
  assign rdata_o     = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      owner_dc_q <= 1'b0;
    end else if (granted) begin
      busy_q     <= 1'b1;
      owner_dc_q <= pick_dc;
    end else if (mem_rvalid_i) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_subsys_settings.svh"

module cache_subsys_top import cache_subsys_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // instruction cache
  input  logic                      ic_enable_i,
  input  logic                      ic_flush_i,
  output logic                      ic_flush_ack_o,
  output logic                      ic_miss_o,
  input  logic                      ic_req_valid_i,
  input  core_req_t                 ic_req_i,
  output logic                      ic_rsp_valid_o,
  output logic [`CS_DATA_WIDTH-1:0] ic_rsp_rdata_o,
  // data cache
  input  logic                      dc_enable_i,
  input  logic                      dc_flush_i,
  output logic                      dc_flush_ack_o,
  output logic                      dc_miss_o,
  input  logic                      dc_req_valid_i,
  input  core_req_t                 dc_req_i,
  output logic                      dc_rsp_valid_o,
  output logic [`CS_DATA_WIDTH-1:0] dc_rsp_rdata_o,
  // shared memory bus
  output logic                      mem_req_valid_o,
  output mem_req_t                  mem_req_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  logic [`CS_DATA_WIDTH-1:0] mem_rdata_i
);

  logic                      ic_mem_req_valid;
  mem_req_t                  ic_mem_req;
  logic                      ic_mem_gnt;
  logic                      ic_mem_rvalid;
  logic                      dc_mem_req_valid;
  mem_req_t                  dc_mem_req;
  logic                      dc_mem_gnt;
  logic                      dc_mem_rvalid;
  logic [`CS_DATA_WIDTH-1:0] arb_rdata;

  icache_ctrl #(
    .NUM_LINES(`CS_ICACHE_LINES)
  ) i_icache_ctrl (
    .clk_i,
    .rst_ni,
    .enable_i       (ic_enable_i),
    .flush_i        (ic_flush_i),
    .flush_ack_o    (ic_flush_ack_o),
    .miss_o         (ic_miss_o),
    .req_valid_i    (ic_req_valid_i),
    .req_i          (ic_req_i),
    .rsp_valid_o    (ic_rsp_valid_o),
    .rsp_rdata_o    (ic_rsp_rdata_o),
    .mem_req_valid_o(ic_mem_req_valid),
    .mem_req_o      (ic_mem_req),
    .mem_gnt_i      (ic_mem_gnt),
    .mem_rvalid_i   (ic_mem_rvalid),
    .mem_rdata_i    (arb_rdata)
  );

  dcache_ctrl #(
    .NUM_LINES(`CS_DCACHE_LINES)
  ) i_dcache_ctrl (
    .clk_i,
    .rst_ni,
    .enable_i       (dc_enable_i),
    .flush_i        (dc_flush_i),
    .flush_ack_o    (dc_flush_ack_o),
    .miss_o         (dc_miss_o),
    .req_valid_i    (dc_req_valid_i),
    .req_i          (dc_req_i),
    .rsp_valid_o    (dc_rsp_valid_o),
    .rsp_rdata_o    (dc_rsp_rdata_o),
    .mem_req_valid_o(dc_mem_req_valid),
    .mem_req_o      (dc_mem_req),
    .mem_gnt_i      (dc_mem_gnt),
    .mem_rvalid_i   (dc_mem_rvalid),
    .mem_rdata_i    (arb_rdata)
  );

  mem_arbiter i_mem_arbiter (
    .clk_i,
    .rst_ni,
    .ic_req_valid_i (ic_mem_req_valid),
    .ic_req_i       (ic_mem_req),
    .ic_gnt_o       (ic_mem_gnt),
    .ic_rvalid_o    (ic_mem_rvalid),
    .dc_req_valid_i (dc_mem_req_valid),
    .dc_req_i       (dc_mem_req),
    .dc_gnt_o       (dc_mem_gnt),
    .dc_rvalid_o    (dc_mem_rvalid),
    .rdata_o        (arb_rdata),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rdata_i    (mem_rdata_i)
  );

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_subsys_settings.svh"

module tb_mem_model import cache_subsys_pkg::*; #(
  parameter int unsigned               LATENCY = 2,
  parameter logic [`CS_DATA_WIDTH-1:0] PATTERN = '0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  input  mem_req_t                  req_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [`CS_DATA_WIDTH-1:0] rdata_o,
  output int unsigned               txn_count_o
);

  logic [`CS_DATA_WIDTH-1:0] mem_q [logic [`CS_ADDR_WIDTH-1:0]];
  logic                      busy_q;
  int unsigned               wait_q;
  mem_req_t                  req_q;

  function automatic logic [`CS_ADDR_WIDTH-1:0] word_key(
    input logic [`CS_ADDR_WIDTH-1:0] addr
  );
    return {addr[`CS_ADDR_WIDTH-1:2], 2'b00};
  endfunction

  // unwritten words follow the address pattern
  function automatic logic [`CS_DATA_WIDTH-1:0] stored_word(
    input logic [`CS_ADDR_WIDTH-1:0] addr
  );
    if (mem_q.exists(word_key(addr))) begin
      return mem_q[word_key(addr)];
    end
    return word_key(addr) ^ PATTERN;
  endfunction

  // grant whenever no transaction is open
  assign gnt_o = !busy_q;

  // write data lands in the store at grant
  always @(posedge clk_i) begin
    if (req_valid_i && gnt_o && (req_i.op == MEM_WRITE)) begin
      mem_q[word_key(req_i.addr)] = req_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      wait_q      <= 0;
      req_q       <= '0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
      txn_count_o <= 0;
    end else begin
      rvalid_o <= 1'b0;
      if (req_valid_i && gnt_o) begin
        busy_q <= 1'b1;
        wait_q <= LATENCY - 1;
        req_q  <= req_i;
      end else if (busy_q && (wait_q != 0)) begin
        wait_q <= wait_q - 1;
      end else if (busy_q) begin
        busy_q      <= 1'b0;
        rvalid_o    <= 1'b1;
        rdata_o     <= (req_q.op == MEM_WRITE) ? '0 : stored_word(req_q.addr);
        txn_count_o <= txn_count_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_cache_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_subsys_settings.svh"

module tb_cache_subsys import cache_subsys_pkg::*; ();

  localparam int unsigned               LATENCY = 2;
  localparam logic [`CS_DATA_WIDTH-1:0] PATTERN = 32'h5ac3_96e1;
  // roughly 30 accesses of at most 15 cycles each, plus reset, with wide margin
  localparam int unsigned               TIMEOUT_CYCLES = 2000;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      ic_enable, ic_flush, ic_flush_ack, ic_miss;
  logic                      ic_req_valid, ic_rsp_valid;
  core_req_t                 ic_req;
  logic [`CS_DATA_WIDTH-1:0] ic_rdata;
  logic                      dc_enable, dc_flush, dc_flush_ack, dc_miss;
  logic                      dc_req_valid, dc_rsp_valid;
  core_req_t                 dc_req;
  logic [`CS_DATA_WIDTH-1:0] dc_rdata;
  logic                      mem_req_valid, mem_gnt, mem_rvalid;
  mem_req_t                  mem_req;
  logic [`CS_DATA_WIDTH-1:0] mem_rdata;
  int unsigned               txn_count;
  int unsigned               cycle_count = 0;
  int                        seed = 32'he0e428b8;
  logic [`CS_ADDR_WIDTH-1:0] hit_addr [2];
  logic [`CS_DATA_WIDTH-1:0] hit_word [2];

  cache_subsys_top i_cache_subsys_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .ic_enable_i    (ic_enable),
    .ic_flush_i     (ic_flush),
    .ic_flush_ack_o (ic_flush_ack),
    .ic_miss_o      (ic_miss),
    .ic_req_valid_i (ic_req_valid),
    .ic_req_i       (ic_req),
    .ic_rsp_valid_o (ic_rsp_valid),
    .ic_rsp_rdata_o (ic_rdata),
    .dc_enable_i    (dc_enable),
    .dc_flush_i     (dc_flush),
    .dc_flush_ack_o (dc_flush_ack),
    .dc_miss_o      (dc_miss),
    .dc_req_valid_i (dc_req_valid),
    .dc_req_i       (dc_req),
    .dc_rsp_valid_o (dc_rsp_valid),
    .dc_rsp_rdata_o (dc_rdata),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_o      (mem_req),
    .mem_gnt_i      (mem_gnt),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rdata_i    (mem_rdata)
  );

  tb_mem_model #(
    .LATENCY(LATENCY),
    .PATTERN(PATTERN)
  ) i_mem_model (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_valid_i(mem_req_valid),
    .req_i      (mem_req),
    .gnt_o      (mem_gnt),
    .rvalid_o   (mem_rvalid),
    .rdata_o    (mem_rdata),
    .txn_count_o(txn_count)
  );

  always #4 clk = ~clk;

  task automatic stop_run(input string line);
    $display("*** FAILED ***");
    $display("%s", line);
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("[ERROR] %0t: %s", $time, msg));
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else value_error($sformatf("%s: got %0h, expected %0h", what, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_run("timeout: the DUT did not finish the tests within the cycle limit");
    end
  end

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [`CS_ADDR_WIDTH-1:0] rand_addr();
    return $random(seed) & 32'hffff_fffc;
  endfunction

  // memory rule for words never written
  function automatic logic [`CS_DATA_WIDTH-1:0] pattern_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ PATTERN;
  endfunction

  task automatic core_access(input bit use_dc, input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int cycles, output int misses, output int unsigned ends);
    core_req_t req;
    bit        done;
    req    = '{op: op, addr: addr, wdata: wdata};
    cycles = 0;
    misses = 0;
    done   = 1'b0;
    if (use_dc) begin
      dc_req       = req;
      dc_req_valid = 1'b1;
    end else begin
      ic_req       = req;
      ic_req_valid = 1'b1;
    end
    while (!done) begin
      next_cycle();
      cycles++;
      misses += use_dc ? dc_miss : ic_miss;
      if (use_dc ? dc_rsp_valid : ic_rsp_valid) begin
        done  = 1'b1;
        rdata = use_dc ? dc_rdata : ic_rdata;
        ends  = cycle_count;
        if (use_dc) dc_req_valid = 1'b0;
        else ic_req_valid = 1'b0;
      end
    end
    // one quiet cycle so the next request starts from idle
    next_cycle();
  endtask

  task automatic flush_cache(input bit use_dc);
    bit seen;
    seen = 1'b0;
    if (use_dc) dc_flush = 1'b1;
    else ic_flush = 1'b1;
    while (!seen) begin
      next_cycle();
      if (use_dc ? dc_flush_ack : ic_flush_ack) begin
        seen     = 1'b1;
        dc_flush = 1'b0;
        ic_flush = 1'b0;
      end
    end
    next_cycle();
    check_eq("flush ack longer than one cycle", use_dc ? dc_flush_ack : ic_flush_ack, 0);
  endtask

  task automatic icache_miss_hit_test();
    logic [31:0] addr, rdata;
    int          cycles, misses;
    int unsigned ends, txn0;
    addr = rand_addr();
    txn0 = txn_count;
    core_access(1'b0, MEM_READ, addr, '0, rdata, cycles, misses, ends);
    check_eq("icache miss data", rdata, pattern_word(addr));
    check_eq("icache miss pulses", misses, 1);
    check_eq("icache miss transactions", txn_count - txn0, 1);
    core_access(1'b0, MEM_READ, addr, '0, rdata, cycles, misses, ends);
    check_eq("icache hit data", rdata, pattern_word(addr));
    check_eq("icache hit latency", cycles, 2);
    check_eq("icache hit miss pulses", misses, 0);
    check_eq("icache hit transactions", txn_count - txn0, 1);
    hit_addr[0] = addr;
    hit_word[0] = pattern_word(addr);
  endtask

  task automatic dcache_write_through_test();
    logic [31:0] addr, other, wval, w2, rdata;
    int          cycles, misses;
    int unsigned ends, txn0;
    addr  = rand_addr();
    other = addr ^ 32'h8000_0000;
    wval  = $random(seed);
    w2    = $random(seed);
    core_access(1'b1, MEM_READ, addr, '0, rdata, cycles, misses, ends);
    check_eq("dcache fill data", rdata, pattern_word(addr));
    check_eq("dcache fill miss pulses", misses, 1);
    txn0 = txn_count;
    core_access(1'b1, MEM_WRITE, addr, wval, rdata, cycles, misses, ends);
    check_eq("dcache write response data", rdata, 0);
    check_eq("dcache write miss pulses", misses, 0);
    core_access(1'b1, MEM_READ, addr, '0, rdata, cycles, misses, ends);
    check_eq("dcache read after write", rdata, wval);
    check_eq("dcache read after write latency", cycles, 2);
    check_eq("dcache write transactions", txn_count - txn0, 1);
    check_eq("memory after write-through", i_mem_model.stored_word(addr), wval);
    // same index, other tag, so the write must not allocate
    core_access(1'b1, MEM_WRITE, other, w2, rdata, cycles, misses, ends);
    core_access(1'b1, MEM_READ, other, '0, rdata, cycles, misses, ends);
    check_eq("dcache no write allocate", misses, 1);
    check_eq("dcache read of written word", rdata, w2);
    hit_addr[1] = other;
    hit_word[1] = w2;
  endtask

  task automatic flush_test();
    logic [31:0] rdata;
    int          cycles, misses;
    int unsigned ends;
    for (int c = 0; c < 2; c++) begin
      core_access(c == 1, MEM_READ, hit_addr[c], '0, rdata, cycles, misses, ends);
      check_eq($sformatf("cache %0d hit before flush", c), cycles, 2);
      flush_cache(c == 1);
      core_access(c == 1, MEM_READ, hit_addr[c], '0, rdata, cycles, misses, ends);
      check_eq($sformatf("cache %0d miss after flush", c), misses, 1);
      check_eq($sformatf("cache %0d data after flush", c), rdata, hit_word[c]);
    end
  endtask

  task automatic disable_test();
    logic [31:0] rdata;
    int          cycles, misses;
    int unsigned ends, txn0;
    for (int c = 0; c < 2; c++) begin
      if (c == 1) dc_enable = 1'b0;
      else ic_enable = 1'b0;
      txn0 = txn_count;
      repeat (2) begin
        core_access(c == 1, MEM_READ, hit_addr[c], '0, rdata, cycles, misses, ends);
        check_eq($sformatf("cache %0d disabled data", c), rdata, hit_word[c]);
        check_eq($sformatf("cache %0d disabled miss pulses", c), misses, 0);
      end
      check_eq($sformatf("cache %0d disabled transactions", c), txn_count - txn0, 2);
      dc_enable = 1'b1;
      ic_enable = 1'b1;
    end
  endtask

  task automatic shared_bus_test();
    logic [31:0] ic_a, dc_a, ic_d, dc_d;
    int          ic_cyc, dc_cyc, ic_ms, dc_ms;
    int unsigned ic_end, dc_end, txn0;
    ic_a = rand_addr();
    dc_a = rand_addr();
    if (dc_a == ic_a) dc_a = dc_a ^ 32'h10;
    txn0 = txn_count;
    fork
      core_access(1'b0, MEM_READ, ic_a, '0, ic_d, ic_cyc, ic_ms, ic_end);
      core_access(1'b1, MEM_READ, dc_a, '0, dc_d, dc_cyc, dc_ms, dc_end);
    join
    check_eq("shared bus icache data", ic_d, pattern_word(ic_a));
    check_eq("shared bus dcache data", dc_d, pattern_word(dc_a));
    check_eq("shared bus icache miss pulses", ic_ms, 1);
    check_eq("shared bus dcache miss pulses", dc_ms, 1);
    check_eq("shared bus transactions", txn_count - txn0, 2);
    assert (dc_end < ic_end) else value_error("data cache response did not arrive first");
  endtask

  initial begin
    rst_n        = 1'b0;
    ic_enable    = 1'b1;
    ic_flush     = 1'b0;
    ic_req_valid = 1'b0;
    ic_req       = '0;
    dc_enable    = 1'b1;
    dc_flush     = 1'b0;
    dc_req_valid = 1'b0;
    dc_req       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    icache_miss_hit_test();
    dcache_write_through_test();
    flush_test();
    disable_test();
    shared_bus_test();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/cache_subsys_pkg.sv
src/icache_ctrl.sv
src/dcache_ctrl.sv
src/mem_arbiter.sv
src/cache_subsys_top.sv
test/tb_mem_model.sv
test/tb_cache_subsys.sv

// ==== Bender.yml ====
package:
  name: cache_subsys

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cache_subsys_pkg.sv
      - src/icache_ctrl.sv
      - src/dcache_ctrl.sv
      - src/mem_arbiter.sv
      - src/cache_subsys_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_mem_model.sv
      - test/tb_cache_subsys.sv
